// ==== blas_engine.f ====
+incdir+design
design/blas_pkg.sv
design/mpu_axil_slave.sv
design/mpu_seq_fsm.sv
design/elem_counter.sv
design/vec_dmem.sv
design/tpu_mac_lane.sv
design/blas_engine.sv
sim/blas_checker.sv
sim/tb_blas_engine.sv

// ==== design/blas_engine.sv ====
// BLAS engine top with the MPU front end, sequencer, TPU lane and X and Y memories
`timescale 1ns/1ps
`default_nettype none
`include "blas_settings.svh"

module blas_engine import blas_pkg::*; (
	input	logic			clock,
	input	logic			rst_n,
	input	axil_req_t		axi_req,
	output	axil_rsp_t		axi_rsp
);

	eng_stat_t						stat;
	cmd_word_u						cmd;
	lane_ctl_t						lane_ctl;
	mem_req_t						x_host, y_host, eng_rd, y_wr;
	logic							cmd_start, cnt_load, cnt_last, cnt_active;
	logic	[`BLAS_ADDR_W:0]		cnt_len;
	logic	[`BLAS_ADDR_W-1:0]		cnt_idx;
	logic	[`BLAS_ACC_W-1:0]		result;
	logic	[`BLAS_DATA_W-1:0]		x_rdata, y_rdata;

	// Shared read request for both memories
	assign eng_rd = '{en: lane_ctl.valid & cnt_active, we: 1'b0, addr: lane_ctl.addr, wdata: '0};

	mpu_axil_slave u_slave (
		.clock		(clock),		.rst_n		(rst_n),
		.axi_req	(axi_req),		.axi_rsp	(axi_rsp),
		.stat		(stat),			.result		(result),
		.cmd		(cmd),			.cmd_start	(cmd_start),
		.x_host		(x_host),		.y_host		(y_host),
		.x_rdata	(x_rdata),		.y_rdata	(y_rdata)
	);

	mpu_seq_fsm u_seq (
		.clock		(clock),		.rst_n		(rst_n),
		.cmd		(cmd),			.cmd_start	(cmd_start),
		.cnt_load	(cnt_load),		.cnt_len	(cnt_len),
		.cnt_idx	(cnt_idx),		.cnt_last	(cnt_last),
		.lane_ctl	(lane_ctl),		.stat		(stat)
	);

	elem_counter u_cnt (
		.clock		(clock),		.rst_n		(rst_n),
		.load		(cnt_load),		.len		(cnt_len),
		.idx		(cnt_idx),		.active		(cnt_active),
		.last		(cnt_last)
	);

	tpu_mac_lane u_lane (
		.clock		(clock),		.rst_n		(rst_n),
		.lane_ctl	(lane_ctl),
		.x_data		(x_rdata),		.y_data		(y_rdata),
		.y_wr		(y_wr),			.result		(result)
	);

	////////////////////////////////////////
	// Only Y takes engine writes
	vec_dmem x_mem (
		.clock(clock), .rst_n(rst_n), .host(x_host), .eng_rd(eng_rd), .eng_wr('0), .rdata(x_rdata)
	);

	vec_dmem y_mem (
		.clock(clock), .rst_n(rst_n), .host(y_host), .eng_rd(eng_rd), .eng_wr(y_wr), .rdata(y_rdata)
	);

endmodule

`default_nettype wire

// ==== design/blas_pkg.sv ====
// BLAS engine types for opcodes, command word views and bus structs
`default_nettype none
`include "blas_settings.svh"

package blas_pkg;

	typedef enum logic [1:0] {
		OP_DOT	= 2'd0,
		OP_AXPY	= 2'd1,
		OP_SCAL	= 2'd2,
		OP_BAD	= 2'd3
	} blas_op_e;

	typedef struct packed {
		blas_op_e						op;
		logic	[6:0]					len;		// 1 to 64
		logic	[6:0]					reserved;
		logic	[`BLAS_DATA_W-1:0]		alpha;		// Q8.8
	} scal_cmd_t;

	typedef struct packed {
		blas_op_e						op;
		logic	[6:0]					len;
		logic	[4:0]					shift;
		logic	[17:0]					reserved;
	} dot_cmd_t;

	typedef union packed {
		scal_cmd_t						scal;
		dot_cmd_t						dot;
	} cmd_word_u;

	typedef struct packed {
		logic							awvalid;
		logic	[`BLAS_AXI_ADDR_W-1:0]	awaddr;
		logic							wvalid;
		logic	[31:0]					wdata;
		logic							bready;
		logic							arvalid;
		logic	[`BLAS_AXI_ADDR_W-1:0]	araddr;
		logic							rready;
	} axil_req_t;

	typedef struct packed {
		logic							awready;
		logic							wready;
		logic							bvalid;
		logic	[1:0]					bresp;
		logic							arready;
		logic							rvalid;
		logic	[31:0]					rdata;
		logic	[1:0]					rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic							en;
		logic							we;
		logic	[`BLAS_ADDR_W-1:0]		addr;
		logic	[`BLAS_DATA_W-1:0]		wdata;
	} mem_req_t;

	typedef struct packed {
		logic							valid;
		blas_op_e						op;
		logic							last;
		logic	[`BLAS_ADDR_W-1:0]		addr;
		logic	[`BLAS_DATA_W-1:0]		alpha;
		logic	[4:0]					shift;
	} lane_ctl_t;

	typedef struct packed {
		logic							busy;
		logic							done;
		logic							err;
	} eng_stat_t;

endpackage

`default_nettype wire

// ==== design/blas_settings.svh ====
// BLAS engine settings for element widths, memory depth and bus widths
`ifndef BLAS_SETTINGS_SVH
`define BLAS_SETTINGS_SVH

// Element and accumulator widths
`define BLAS_DATA_W		16
`define BLAS_ACC_W		32

// Vector memories
`define BLAS_VEC_DEPTH	64
`define BLAS_ADDR_W		6

// Host bus
`define BLAS_AXI_ADDR_W	12

// Alpha is signed Q8.8
`define BLAS_ALPHA_FRAC	8

`endif

// ==== design/elem_counter.sv ====
// Element counter that steps an index once per cycle over a loaded length
`timescale 1ns/1ps
`default_nettype none
`include "blas_settings.svh"

module elem_counter (
	input	logic						clock,
	input	logic						rst_n,
	input	logic						load,
	input	logic	[`BLAS_ADDR_W:0]	len,
	output	logic	[`BLAS_ADDR_W-1:0]	idx,
	output	logic						active,
	output	logic						last
);

	logic	[`BLAS_ADDR_W:0]	len_q;

	// Zero length ends at once and oversize lengths stop at the memory end
	assign last = active && (({1'b0, idx} + 1'b1 >= len_q) || (&idx));

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			active	<= 1'b0;
			idx		<= '0;
			len_q	<= '0;
		end else if (load) begin
			active	<= 1'b1;
			idx		<= '0;
			len_q	<= len;
		end else if (active) begin
			if (last) active <= 1'b0;
			else idx <= idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/mpu_axil_slave.sv ====
// MPU front end that serves command, status, result and vector memory access over AXI4-Lite
`timescale 1ns/1ps
`default_nettype none
`include "blas_settings.svh"

module mpu_axil_slave import blas_pkg::*; (
	input	logic						clock,
	input	logic						rst_n,
	input	axil_req_t					axi_req,
	output	axil_rsp_t					axi_rsp,
	input	eng_stat_t					stat,
	input	logic	[`BLAS_ACC_W-1:0]	result,
	output	cmd_word_u					cmd,
	output	logic						cmd_start,
	output	mem_req_t					x_host,
	output	mem_req_t					y_host,
	input	logic	[`BLAS_DATA_W-1:0]	x_rdata,
	input	logic	[`BLAS_DATA_W-1:0]	y_rdata
);

	localparam logic [1:0]	RESP_OKAY	= 2'b00;
	localparam logic [1:0]	RESP_SLVERR	= 2'b10;
	localparam logic [3:0]	REG_PAGE	= 4'h0;
	localparam logic [3:0]	X_PAGE		= 4'h4;
	localparam logic [3:0]	Y_PAGE		= 4'h8;
	localparam logic [1:0]	RD_STAT		= 2'd0;
	localparam logic [1:0]	RD_RES		= 2'd1;
	localparam logic [1:0]	RD_X		= 2'd2;
	localparam logic [1:0]	RD_Y		= 2'd3;

	logic			live;
	logic			bvalid_q, arready_q, rd_s1, rvalid_q;
	logic	[1:0]	bresp_q, rresp_q;
	logic	[31:0]	rdata_q, rd_word;
	logic	[1:0]	rd_sel, ar_sel;
	logic			rd_err, ar_ok;
	logic	[3:0]	aw_page, ar_page;
	logic			ar_hs, wr_go, wr_cmd, wr_ok;
	logic			x_wr, y_wr, x_rd, y_rd;

	function automatic mem_req_t host_req(input logic wr, input logic rd, input axil_req_t r);
		mem_req_t q;
		q.en	= wr | rd;
		q.we	= wr;
		q.addr	= wr ? r.awaddr[2 +: `BLAS_ADDR_W] : r.araddr[2 +: `BLAS_ADDR_W];
		q.wdata	= r.wdata[`BLAS_DATA_W-1:0];
		return q;
	endfunction

	////////////////////////////////////////
	// Address decode
	always_comb begin
		aw_page	= axi_req.awaddr[11:8];
		ar_page	= axi_req.araddr[11:8];
		ar_hs	= axi_req.arvalid & arready_q;
		// A same-page read takes the host port first and the write waits
		wr_go	= axi_req.awvalid & axi_req.wvalid & !bvalid_q & live &
				  !(ar_hs && aw_page == ar_page && aw_page != REG_PAGE);
		wr_cmd	= wr_go && axi_req.awaddr == '0 && !stat.busy;
		x_wr	= wr_go && aw_page == X_PAGE && !stat.busy;
		y_wr	= wr_go && aw_page == Y_PAGE && !stat.busy;
		wr_ok	= wr_cmd | x_wr | y_wr;

		ar_sel	= RD_STAT;
		ar_ok	= 1'b0;
		case (ar_page)
			REG_PAGE: begin
				if (axi_req.araddr == 12'h004) ar_ok = 1'b1;
				if (axi_req.araddr == 12'h008) begin
					ar_sel	= RD_RES;
					ar_ok	= 1'b1;
				end
			end
			X_PAGE: begin
				ar_sel	= RD_X;
				ar_ok	= !stat.busy;		// Memory locked while running
			end
			Y_PAGE: begin
				ar_sel	= RD_Y;
				ar_ok	= !stat.busy;
			end
			default: ar_ok = 1'b0;
		endcase
		x_rd	= ar_hs && ar_page == X_PAGE && !stat.busy;
		y_rd	= ar_hs && ar_page == Y_PAGE && !stat.busy;

		x_host	= host_req(x_wr, x_rd, axi_req);
		y_host	= host_req(y_wr, y_rd, axi_req);
	end

	always_comb begin
		case (rd_sel)
			RD_STAT:	rd_word = {29'd0, stat.err, stat.done, stat.busy};
			RD_RES:		rd_word = result;
			RD_X:		rd_word = {{(32-`BLAS_DATA_W){x_rdata[`BLAS_DATA_W-1]}}, x_rdata};
			default:	rd_word = {{(32-`BLAS_DATA_W){y_rdata[`BLAS_DATA_W-1]}}, y_rdata};
		endcase
		if (rd_err) rd_word = '0;
	end

	////////////////////////////////////////
	// Channel state
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			live		<= 1'b0;
			bvalid_q	<= 1'b0;
			bresp_q		<= RESP_OKAY;
			cmd_start	<= 1'b0;
			cmd			<= '0;
			arready_q	<= 1'b0;
			rd_s1		<= 1'b0;
			rd_sel		<= RD_STAT;
			rd_err		<= 1'b0;
			rvalid_q	<= 1'b0;
			rresp_q		<= RESP_OKAY;
		end else begin
			live		<= 1'b1;
			cmd_start	<= wr_cmd;
			if (wr_cmd) cmd <= axi_req.wdata;
			if (wr_go) begin
				bvalid_q	<= 1'b1;
				bresp_q		<= wr_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (axi_req.bready) begin
				bvalid_q	<= 1'b0;
			end
			arready_q	<= !ar_hs && !rd_s1 && !(rvalid_q && !axi_req.rready);
			rd_s1		<= ar_hs;		// Memory data lands one cycle later
			if (ar_hs) begin
				rd_sel	<= ar_sel;
				rd_err	<= !ar_ok;
			end
			if (rd_s1) begin
				rvalid_q	<= 1'b1;
				rresp_q		<= rd_err ? RESP_SLVERR : RESP_OKAY;
			end else if (axi_req.rready) begin
				rvalid_q	<= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_s1) rdata_q <= rd_word;
	end

	always_comb begin
		axi_rsp.awready	= wr_go;
		axi_rsp.wready	= wr_go;
		axi_rsp.bvalid	= bvalid_q;
		axi_rsp.bresp	= bresp_q;
		axi_rsp.arready	= arready_q;
		axi_rsp.rvalid	= rvalid_q;
		axi_rsp.rdata	= rdata_q;
		axi_rsp.rresp	= rresp_q;
	end

endmodule

`default_nettype wire

// ==== design/mpu_seq_fsm.sv ====
// MPU sequencer that runs a command through its load, compute and drain phases
`timescale 1ns/1ps
`default_nettype none
`include "blas_settings.svh"

module mpu_seq_fsm import blas_pkg::*; (
	input	logic						clock,
	input	logic						rst_n,
	input	cmd_word_u					cmd,
	input	logic						cmd_start,
	output	logic						cnt_load,
	output	logic	[6:0]				cnt_len,
	input	logic	[`BLAS_ADDR_W-1:0]	cnt_idx,
	input	logic						cnt_last,
	output	lane_ctl_t					lane_ctl,
	output	eng_stat_t					stat
);

	localparam logic [1:0]	S_IDLE	= 2'd0;
	localparam logic [1:0]	S_RUN	= 2'd1;
	localparam logic [1:0]	S_DRAIN	= 2'd2;

	logic	[1:0]	state;
	logic	[1:0]	drain_cnt;
	logic			is_dot;

	always_comb begin
		is_dot			= cmd.dot.op == OP_DOT;
		cnt_load		= cmd_start && state == S_IDLE && cmd.dot.op != OP_BAD;
		cnt_len			= cmd.scal.len;
		lane_ctl.valid	= state == S_RUN;
		lane_ctl.op		= cmd.dot.op;
		lane_ctl.last	= cnt_last;
		lane_ctl.addr	= cnt_idx;
		lane_ctl.alpha	= is_dot ? '0 : cmd.scal.alpha;		// AXPY and SCAL view
		lane_ctl.shift	= is_dot ? cmd.dot.shift : '0;		// DOT view
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state		<= S_IDLE;
			drain_cnt	<= '0;
			stat		<= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (cmd_start) begin
						if (cmd.dot.op == OP_BAD) begin
							stat.err	<= 1'b1;
							stat.done	<= 1'b1;
						end else begin
							state		<= S_RUN;
							stat		<= '{busy: 1'b1, done: 1'b0, err: 1'b0};
						end
					end
				end
				S_RUN: begin
					if (cnt_last) begin
						state		<= S_DRAIN;
						drain_cnt	<= '0;
					end
				end
				S_DRAIN: begin
					// Read, product and write-back stages empty out
					drain_cnt	<= drain_cnt + 2'd1;
					if (drain_cnt == 2'd2) begin
						state		<= S_IDLE;
						stat.busy	<= 1'b0;
						stat.done	<= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/tpu_mac_lane.sv ====
// TPU lane that multiplies, then accumulates or scales and writes back to Y
`timescale 1ns/1ps
`default_nettype none
`include "blas_settings.svh"

module tpu_mac_lane import blas_pkg::*; (
	input	logic						clock,
	input	logic						rst_n,
	input	lane_ctl_t					lane_ctl,
	input	logic	[`BLAS_DATA_W-1:0]	x_data,
	input	logic	[`BLAS_DATA_W-1:0]	y_data,
	output	mem_req_t					y_wr,
	output	logic	[`BLAS_ACC_W-1:0]	result
);

	lane_ctl_t							ctl_d1, ctl_d2;
	logic	signed	[`BLAS_DATA_W-1:0]	mul_a, mul_b;
	logic	signed	[`BLAS_ACC_W-1:0]	prod_q, acc, acc_next, scaled;
	logic			[`BLAS_DATA_W-1:0]	y_q;

	////////////////////////////////////////
	// Stage 1 takes operands from memory
	always_comb begin
		mul_a = (ctl_d1.op == OP_DOT) ? y_data : ctl_d1.alpha;
		mul_b = (ctl_d1.op == OP_SCAL) ? y_data : x_data;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ctl_d1	<= '0;
			ctl_d2	<= '0;
		end else begin
			ctl_d1	<= lane_ctl;		// Lines up with read data
			ctl_d2	<= ctl_d1;
		end
	end

	always_ff @(posedge clock) begin
		prod_q	<= mul_a * mul_b;
		y_q		<= y_data;
	end

	////////////////////////////////////////
	// Stage 2 accumulates or writes back
	always_comb begin
		acc_next	= ((ctl_d2.addr == '0) ? '0 : acc) + prod_q;	// Wraps
		scaled		= prod_q >>> `BLAS_ALPHA_FRAC;
		y_wr.en		= ctl_d2.valid && ctl_d2.op != OP_DOT;
		y_wr.we		= 1'b1;
		y_wr.addr	= ctl_d2.addr;
		y_wr.wdata	= (ctl_d2.op == OP_AXPY) ? y_q + scaled[`BLAS_DATA_W-1:0]
											 : scaled[`BLAS_DATA_W-1:0];
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			acc		<= '0;
			result	<= '0;
		end else if (ctl_d2.valid && ctl_d2.op == OP_DOT) begin
			acc <= acc_next;
			if (ctl_d2.last) result <= acc_next >>> ctl_d2.shift;
		end
	end

endmodule

`default_nettype wire

// ==== design/vec_dmem.sv ====
// Vector data memory with one synchronous read port, one write port and engine priority
`timescale 1ns/1ps
`default_nettype none
`include "blas_settings.svh"

module vec_dmem import blas_pkg::*; (
	input	logic						clock,
	input	logic						rst_n,
	input	mem_req_t					host,
	input	mem_req_t					eng_rd,
	input	mem_req_t					eng_wr,
	output	logic	[`BLAS_DATA_W-1:0]	rdata
);

	logic	[`BLAS_DATA_W-1:0]	mem	[`BLAS_VEC_DEPTH];
	logic						rd_en, wr_en, eng_rd_en, eng_wr_en;
	logic	[`BLAS_ADDR_W-1:0]	rd_addr, wr_addr;
	logic	[`BLAS_DATA_W-1:0]	wr_data;

	always_comb begin
		eng_rd_en	= eng_rd.en & !eng_rd.we;
		eng_wr_en	= eng_wr.en & eng_wr.we;
		rd_en		= eng_rd_en | (host.en & !host.we);
		rd_addr		= eng_rd_en ? eng_rd.addr : host.addr;
		wr_en		= eng_wr_en | (host.en & host.we);
		wr_addr		= eng_wr_en ? eng_wr.addr : host.addr;
		wr_data		= eng_wr_en ? eng_wr.wdata : host.wdata;
	end

	always_ff @(posedge clock) begin
		if (wr_en) mem[wr_addr] <= wr_data;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) rdata <= '0;
		else if (rd_en) rdata <= mem[rd_addr];		// Old data on same-address write
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the BLAS engine testbench with Verilator
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal -f blas_engine.f \
	--top-module tb_blas_engine -o sim_blas > build.log 2>&1 &&
./obj_dir/sim_blas > sim.log 2>&1 ||
echo "build or run failed, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "^=== PASS ===$" sim.log 2>/dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim/blas_checker.sv ====
// BLAS checker that models X, Y, status and RESULT from bus traffic and checks every response
`timescale 1ns/1ps
`default_nettype none
`include "blas_settings.svh"

module blas_checker import blas_pkg::*; (
	input	logic		clock,
	input	logic		rst_n,
	input	axil_req_t	axi_req,
	input	axil_rsp_t	axi_rsp
);

	logic	[15:0]	x_m	[`BLAS_VEC_DEPTH];
	logic	[15:0]	y_m	[`BLAS_VEC_DEPTH];
	logic	[31:0]	res_m, hold_d, exp_d;
	logic			busy_m, done_m, err_m, hold_v, ar_d, ar_ok_d, ok;
	logic	[11:0]	ar_addr_d, a;
	logic	[1:0]	bresp_q[$], rresp_q[$];
	logic	[31:0]	rdata_q[$];
	logic	[11:0]	raddr_q[$];
	cmd_word_u		run_cmd;
	int				cyc, set_at, clr_at, bad_at, run_len;
	int				mismatch_cnt, resp_cnt;

	function automatic logic [31:0] ref_dot(input int n, input int sh);
		int acc;
		acc = 0;
		for (int i = 0; i < n; i++) acc += int'($signed(x_m[i])) * int'($signed(y_m[i]));
		return acc >>> sh;		// Wraps in 32 bits
	endfunction

	function automatic logic [15:0] ref_elem(input blas_op_e op, input logic [15:0] alpha,
											 input logic [15:0] x, input logic [15:0] y);
		int p;
		if (op == OP_SCAL) p = int'($signed(alpha)) * int'($signed(y));
		else p = int'($signed(alpha)) * int'($signed(x));
		p = p >>> `BLAS_ALPHA_FRAC;
		if (op == OP_AXPY) return y + p[15:0];
		return p[15:0];
	endfunction

	task automatic start_cmd(input logic [31:0] d);
		run_cmd = d;
		run_len = (d[29:23] == 0) ? 1 : (d[29:23] > 64) ? 64 : int'(d[29:23]);
		if (run_cmd.dot.op == OP_BAD) begin
			bad_at = cyc + 2;
		end else begin
			set_at = cyc + 2;
			clr_at = cyc + run_len + 5;		// busy for len+3 cycles
		end
	endtask

	task automatic finish_cmd();
		if (run_cmd.dot.op == OP_DOT) res_m = ref_dot(run_len, run_cmd.dot.shift);
		else for (int i = 0; i < run_len; i++)
			y_m[i] = ref_elem(run_cmd.scal.op, run_cmd.scal.alpha, x_m[i], y_m[i]);
	endtask

	always @(posedge clock) begin
		if (!rst_n) begin
			cyc = 0;
			{busy_m, done_m, err_m, hold_v, ar_d} = '0;
			res_m = '0;
			set_at = -1;
			clr_at = -1;
			bad_at = -1;
		end else begin
			cyc++;
			// Status model for this sample
			if (cyc == set_at) {busy_m, done_m, err_m} = 3'b100;
			if (cyc == clr_at) begin
				busy_m = 1'b0;
				done_m = 1'b1;
				finish_cmd();
			end
			if (cyc == bad_at) {done_m, err_m} = 2'b11;

			////////////////////////////////////////
			// Write channel
			if (axi_rsp.awready != axi_rsp.wready) begin
				$display("Write address and write data ready differ at %0t", $time);
				resp_cnt++;
			end
			if (axi_req.awvalid && axi_rsp.awready) begin
				a = axi_req.awaddr;
				ok = !busy_m && (a == 12'h000 || a[11:8] == 4'h4 || a[11:8] == 4'h8);
				if (ok && a == 12'h000) start_cmd(axi_req.wdata);
				else if (ok && a[11:8] == 4'h4) x_m[a[7:2]] = axi_req.wdata[15:0];
				else if (ok) y_m[a[7:2]] = axi_req.wdata[15:0];
				bresp_q.push_back(ok ? 2'b00 : 2'b10);
			end
			if (axi_rsp.bvalid && axi_req.bready) begin
				if (bresp_q.size() == 0) begin
					$display("Write response at %0t without an accepted write", $time);
					resp_cnt++;
				end else if (bresp_q.pop_front() != axi_rsp.bresp) begin
					$display("Wrong write response %0d at %0t", axi_rsp.bresp, $time);
					resp_cnt++;
				end
			end

			////////////////////////////////////////
			// Read channel
			if (ar_d) begin
				case (ar_addr_d[11:8])
					4'h4: exp_d = {{16{x_m[ar_addr_d[7:2]][15]}}, x_m[ar_addr_d[7:2]]};
					4'h8: exp_d = {{16{y_m[ar_addr_d[7:2]][15]}}, y_m[ar_addr_d[7:2]]};
					default: exp_d = (ar_addr_d == 12'h008) ? res_m
									 : {29'd0, err_m, done_m, busy_m};
				endcase
				rdata_q.push_back(ar_ok_d ? exp_d : 32'd0);
				rresp_q.push_back(ar_ok_d ? 2'b00 : 2'b10);
				raddr_q.push_back(ar_addr_d);
			end
			ar_d = axi_req.arvalid && axi_rsp.arready;
			if (ar_d) begin
				ar_addr_d = axi_req.araddr;
				ar_ok_d = axi_req.araddr == 12'h004 || axi_req.araddr == 12'h008 ||
						  (!busy_m && (axi_req.araddr[11:8] == 4'h4 ||
									   axi_req.araddr[11:8] == 4'h8));
			end
			if (hold_v && !axi_rsp.rvalid) begin
				$display("Read valid dropped at %0t before the handshake", $time);
				resp_cnt++;
			end
			if (hold_v && axi_rsp.rvalid && axi_rsp.rdata != hold_d) begin
				$display("MISMATCH t=%0t rdata changed under back-pressure: %08h to %08h",
						 $time, hold_d, axi_rsp.rdata);
				mismatch_cnt++;
			end
			if (axi_rsp.rvalid && axi_req.rready) begin
				if (rdata_q.size() == 0) begin
					$display("Read data at %0t without an accepted read", $time);
					resp_cnt++;
				end else begin
					a = raddr_q.pop_front();
					exp_d = rdata_q.pop_front();
					if (rresp_q.pop_front() != axi_rsp.rresp) begin
						$display("Wrong read response %0d for address %03h at %0t",
								 axi_rsp.rresp, a, $time);
						resp_cnt++;
					end
					if (axi_rsp.rdata != exp_d) begin
						$display("MISMATCH t=%0t read %03h: got %08h expected %08h",
								 $time, a, axi_rsp.rdata, exp_d);
						mismatch_cnt++;
					end
				end
			end
			hold_v = axi_rsp.rvalid && !axi_req.rready;
			hold_d = axi_rsp.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_blas_engine.sv ====
// BLAS engine testbench with an AXI4-Lite host, random vectors and commands and a run limit
`timescale 1ns/1ps
`default_nettype none
`include "blas_settings.svh"

module tb_blas_engine import blas_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000;

	logic			clock, rst_n;
	axil_req_t		req;
	axil_rsp_t		rsp;
	logic	[15:0]	lfsr;
	int				cycles;
	logic	[31:0]	rd;
	cmd_word_u		c;

	blas_engine DUT (.clock(clock), .rst_n(rst_n), .axi_req(req), .axi_rsp(rsp));
	blas_checker u_chk (.clock(clock), .rst_n(rst_n), .axi_req(req), .axi_rsp(rsp));

	always #10 clock = !clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic write_word(input logic [11:0] a, input logic [31:0] d);
		logic hs;
		req.awvalid = 1'b1;
		req.awaddr = a;
		req.wvalid = 1'b1;
		req.wdata = d;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clock);
			hs = rsp.awready;
			@(posedge clock);
			#2;
		end
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		req.bready = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clock);
			hs = rsp.bvalid;
			@(posedge clock);
			#2;
		end
		req.bready = 1'b0;
	endtask

	task automatic read_word(input logic [11:0] a, output logic [31:0] d);
		logic hs;
		req.arvalid = 1'b1;
		req.araddr = a;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clock);
			hs = rsp.arready;
			@(posedge clock);
			#2;
		end
		req.arvalid = 1'b0;
		hs = 1'b0;
		while (!hs) begin
			req.rready = rand_bits(2) != 0;		// Random stalls
			@(negedge clock);
			hs = rsp.rvalid && req.rready;
			d = rsp.rdata;
			@(posedge clock);
			#2;
		end
		req.rready = 1'b0;
	endtask

	task automatic wait_done();
		logic [31:0] s;
		s = 32'd1;
		while (s[0] || !s[1]) read_word(12'h004, s);
	endtask

	task automatic read_back();
		logic [31:0] d;
		for (int i = 0; i < `BLAS_VEC_DEPTH; i++) begin
			read_word(12'h400 + 12'(i * 4), d);
			read_word(12'h800 + 12'(i * 4), d);
		end
	endtask

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		req = '0;
		lfsr = 16'd48;
		cycles = 0;
		repeat (4) @(posedge clock);
		#2;
		rst_n = 1'b1;

		////////////////////////////////////////
		// Memory fill, readback and bad addresses
		for (int i = 0; i < `BLAS_VEC_DEPTH; i++) begin
			write_word(12'h400 + 12'(i * 4), rand_bits(16));
			write_word(12'h800 + 12'(i * 4), rand_bits(16));
		end
		read_back();
		read_word(12'h300, rd);
		write_word(12'h00C, 32'h1234);

		// DOT with random length and shift
		c = '0;
		c.dot.op = OP_DOT;
		c.dot.len = 7'(rand_bits(6)) + 7'd1;
		c.dot.shift = 5'(rand_bits(5));
		write_word(12'h000, c);
		wait_done();
		read_word(12'h008, rd);

		// AXPY then SCAL
		c = '0;
		c.scal.op = OP_AXPY;
		c.scal.len = 7'd64;
		c.scal.alpha = 16'(rand_bits(16));
		write_word(12'h000, c);
		wait_done();
		c.scal.op = OP_SCAL;
		c.scal.len = 7'(rand_bits(6)) + 7'd1;
		c.scal.alpha = 16'(rand_bits(16));
		write_word(12'h000, c);
		wait_done();
		read_back();

		////////////////////////////////////////
		// Accesses while busy
		c.scal.len = 7'd64;
		write_word(12'h000, c);
		read_word(12'h004, rd);
		write_word(12'h000, c);
		write_word(12'h404, 32'h5555);
		write_word(12'h808, 32'hAAAA);
		read_word(12'h410, rd);
		wait_done();
		read_back();

		// Bad opcode
		c = '0;
		c.dot.op = OP_BAD;
		c.dot.len = 7'd8;
		write_word(12'h000, c);
		read_word(12'h004, rd);
		read_back();

		$display("Errors: %0d mismatches, %0d response errors",
				 u_chk.mismatch_cnt, u_chk.resp_cnt);
		if (u_chk.mismatch_cnt == 0 && u_chk.resp_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
